// File: verilog/game_defs.svh
// 640x480 at 60 Hz only, one pixel per clock; rectangle bounds are exclusive on both sides
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// ----------------------------------------
// screen and sync timing
// ----------------------------------------
`define HVISIBLE 640
`define HFRONT 16
`define HSYNC 96
`define HBACK 48
// totals follow from the four porches, 800 and 525
`define HTOTAL (`HVISIBLE + `HFRONT + `HSYNC + `HBACK)

`define VVISIBLE 480
`define VFRONT 10
`define VSYNC 2
`define VBACK 33
`define VTOTAL (`VVISIBLE + `VFRONT + `VSYNC + `VBACK)

// ----------------------------------------
// map rectangles, exclusive bounds
// ----------------------------------------
`define BORDERX0 19
`define BORDERX1 620
`define BORDERY0 49
`define BORDERY1 460

`define FLOORX0 31
`define FLOORX1 608
`define FLOORY0 61
`define FLOORY1 448

// shooter sprite box, per-frame step and reset position
`define SPRITESIZE 32
`define STEP 2
`define STARTX 304
`define STARTY 224

`endif

// File: verilog/videoPkg.sv
// coordinates fit 10 bits for an 800x525 raster; colour is 8 bits per channel, no gamma
package videoPkg;

    // ----------------------------------------
    // pixel position
    // ----------------------------------------

    // draw counters and sprite origin share this
    // 10 bits covers 0..1023, enough for 799 and 524
    typedef logic [9:0] coordT;

    // ----------------------------------------
    // colour
    // ----------------------------------------

    // one channel of the 24-bit RGB output
    // 8'h00 is dark, 8'hff full intensity
    typedef logic [7:0] channelT;

    // black is also the transparent sprite colour
    localparam channelT channelOff = 8'h00;

    // full channel, used for white body and red barrel
    localparam channelT channelFull = 8'hff;

endpackage

// File: verilog/gamePkg.sv
// facing encoding is fixed at 2 bits in clockwise order; position is the sprite's upper-left pixel
package gamePkg;

    // position fields reuse the pixel coordinate type
    import videoPkg::*;

    // ----------------------------------------
    // facing
    // ----------------------------------------

    // clockwise from up, so a 90 degree turn is +1
    typedef enum logic [1:0]
    {
        faceUp    = 2'b00,
        faceRight = 2'b01,
        faceDown  = 2'b10,
        faceLeft  = 2'b11
    } facingT;

    // ----------------------------------------
    // shooter position
    // ----------------------------------------

    // upper-left corner of the 32x32 box
    typedef struct packed
    {
        coordT x;
        coordT y;
    } posT;

endpackage

// File: verilog/vgaTiming.sv
// fixed 640x480 raster with negative syncs; the first frameStart comes one full frame after reset
`timescale 1ns/1ps

`include "game_defs.svh"

module vgaTiming
    import videoPkg::*;
(
    input  logic  Clk,
    input  logic  rstN,
    output coordT drawX,
    output coordT drawY,
    output logic  hs,
    output logic  vs,
    output logic  blank,
    output logic  frameStart
);

    // ----------------------------------------
    // frame counters
    // ----------------------------------------

    coordT hCount;
    coordT vCount;
    coordT hNext;
    coordT vNext;
    logic  hWrap;
    logic  vWrap;
    logic  frameStartQ;

    // last column and last line of the raster
    assign hWrap = (hCount == coordT'(`HTOTAL - 1));
    assign vWrap = (vCount == coordT'(`VTOTAL - 1));

    always_comb
    begin
        hNext = hWrap ? '0 : hCount + coordT'(1);
        vNext = vCount;
        // line advances only when the column wraps
        if (hWrap)
            vNext = vWrap ? '0 : vCount + coordT'(1);
    end

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            hCount      <= '0;
            vCount      <= '0;
            frameStartQ <= 1'b0;
        end
        else
        begin
            hCount      <= hNext;
            vCount      <= vNext;
            // registered from the next count, so it sits on the (0,0) clock
            frameStartQ <= (hNext == '0) && (vNext == '0);
        end
    end

    // ----------------------------------------
    // window decode
    // ----------------------------------------

    assign drawX = hCount;
    assign drawY = vCount;

    // hs low for 656..751
    assign hs = !((hCount >= coordT'(`HVISIBLE + `HFRONT)) &&
                  (hCount <  coordT'(`HVISIBLE + `HFRONT + `HSYNC)));

    // vs low for lines 490 and 491
    assign vs = !((vCount >= coordT'(`VVISIBLE + `VFRONT)) &&
                  (vCount <  coordT'(`VVISIBLE + `VFRONT + `VSYNC)));

    assign blank = (hCount >= coordT'(`HVISIBLE)) || (vCount >= coordT'(`VVISIBLE));

    assign frameStart = frameStartQ;

endmodule

// File: verilog/shooterMotion.sv
// keys are sampled only on frameStart and need no debounce; one key acts per frame, up first
`timescale 1ns/1ps

`include "game_defs.svh"

module shooterMotion
    import videoPkg::*, gamePkg::*;
(
    input  logic   Clk,
    input  logic   rstN,
    input  logic   frameStart,
    input  logic   keyUp,
    input  logic   keyRight,
    input  logic   keyDown,
    input  logic   keyLeft,
    output coordT  shooterX,
    output coordT  shooterY,
    output facingT shooterFace
);

    // ----------------------------------------
    // clamp limits
    // ----------------------------------------

    // whole box strictly inside the floor rectangle
    localparam coordT minX = coordT'(`FLOORX0 + 1);
    localparam coordT maxX = coordT'(`FLOORX1 - `SPRITESIZE);
    localparam coordT minY = coordT'(`FLOORY0 + 1);
    localparam coordT maxY = coordT'(`FLOORY1 - `SPRITESIZE);
    localparam coordT step = coordT'(`STEP);

    posT    pos;
    posT    posNext;
    facingT face;
    facingT faceNext;

    // ----------------------------------------
    // next position
    // ----------------------------------------

    always_comb
    begin
        posNext  = pos;
        faceNext = face;
        // priority up, right, down, left
        if (keyUp)
        begin
            faceNext  = faceUp;
            posNext.y = (pos.y < minY + step) ? minY : pos.y - step;
        end
        else if (keyRight)
        begin
            faceNext  = faceRight;
            posNext.x = (pos.x > maxX - step) ? maxX : pos.x + step;
        end
        else if (keyDown)
        begin
            faceNext  = faceDown;
            posNext.y = (pos.y > maxY - step) ? maxY : pos.y + step;
        end
        else if (keyLeft)
        begin
            faceNext  = faceLeft;
            posNext.x = (pos.x < minX + step) ? minX : pos.x - step;
        end
        // no key, hold both
    end

    // update lands the clock after frameStart
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            pos.x <= coordT'(`STARTX);
            pos.y <= coordT'(`STARTY);
            face  <= faceUp;
        end
        else if (frameStart)
        begin
            pos  <= posNext;
            face <= faceNext;
        end
    end

    assign shooterX    = pos.x;
    assign shooterY    = pos.y;
    assign shooterFace = face;

endmodule

// File: verilog/spriteTable.sv
// image is a fixed rule, not a ROM; result is one clock behind drawX/drawY, black means transparent
`timescale 1ns/1ps

`include "game_defs.svh"

module spriteTable
    import videoPkg::*, gamePkg::*;
(
    input  logic    Clk,
    input  logic    rstN,
    input  coordT   drawX,
    input  coordT   drawY,
    input  coordT   shooterX,
    input  coordT   shooterY,
    input  facingT  shooterFace,
    output logic    isShooter,
    output channelT spriteR,
    output channelT spriteG,
    output channelT spriteB
);

    coordT       u;
    coordT       v;
    logic [4:0]  uLo;
    logic [4:0]  vLo;
    logic        inBox;
    logic        body;
    logic        barrel;
    channelT     pixR;
    channelT     pixG;
    channelT     pixB;

    // inclusive range test on a local offset
    function automatic logic inRange(input logic [4:0] a, input int lo, input int hi);
        return (int'(a) >= lo) && (int'(a) <= hi);
    endfunction

    // ----------------------------------------
    // local offsets
    // ----------------------------------------

    // wraps when left of or above the box, caught by inBox
    assign u = drawX - shooterX;
    assign v = drawY - shooterY;

    assign inBox = (drawX >= shooterX) && (u < coordT'(`SPRITESIZE)) &&
                   (drawY >= shooterY) && (v < coordT'(`SPRITESIZE));

    assign uLo = u[4:0];
    assign vLo = v[4:0];

    // ----------------------------------------
    // image rule
    // ----------------------------------------

    // square body in the middle
    assign body = inRange(uLo, 8, 23) && inRange(vLo, 8, 23);

    always_comb
    begin
        // 4-wide barrel on the facing edge
        unique case (shooterFace)
            faceUp:    barrel = inRange(uLo, 14, 17) && inRange(vLo, 0, 7);
            faceRight: barrel = inRange(vLo, 14, 17) && inRange(uLo, 24, 31);
            faceDown:  barrel = inRange(uLo, 14, 17) && inRange(vLo, 24, 31);
            faceLeft:  barrel = inRange(vLo, 14, 17) && inRange(uLo, 0, 7);
            default:   barrel = 1'b0;
        endcase
    end

    always_comb
    begin
        // transparent black unless body or barrel
        pixR = channelOff;
        pixG = channelOff;
        pixB = channelOff;
        if (body)
        begin
            pixR = channelFull;
            pixG = channelFull;
            pixB = channelFull;
        end
        else if (barrel)
            pixR = channelFull;
    end

    // ----------------------------------------
    // output register
    // ----------------------------------------

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            isShooter <= 1'b0;
        else
            isShooter <= inBox && (body || barrel);
    end

    always_ff @(posedge Clk)
    begin
        spriteR <= pixR;
        spriteG <= pixG;
        spriteB <= pixB;
    end

endmodule

// File: verilog/colorMapper.sv
// expects sprite inputs one clock behind drawX/drawY; colour and syncs leave two clocks after timing
`timescale 1ns/1ps

`include "game_defs.svh"

module colorMapper
    import videoPkg::*;
(
    input  logic    Clk,
    input  logic    rstN,
    input  coordT   drawX,
    input  coordT   drawY,
    input  logic    hs,
    input  logic    vs,
    input  logic    blank,
    input  logic    isShooter,
    input  channelT spriteR,
    input  channelT spriteG,
    input  channelT spriteB,
    output channelT vgaR,
    output channelT vgaG,
    output channelT vgaB,
    output logic    vgaHs,
    output logic    vgaVs
);

    coordT   xD;
    coordT   yD;
    logic    hsD;
    logic    vsD;
    logic    blankD;
    logic    inBorder;
    logic    inFloor;
    channelT red;
    channelT green;
    channelT blue;

    // ----------------------------------------
    // align with sprite lookup
    // ----------------------------------------

    always_ff @(posedge Clk)
    begin
        xD <= drawX;
        yD <= drawY;
    end

    // syncs idle high, blank asserted
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            hsD    <= 1'b1;
            vsD    <= 1'b1;
            blankD <= 1'b1;
        end
        else
        begin
            hsD    <= hs;
            vsD    <= vs;
            blankD <= blank;
        end
    end

    // ----------------------------------------
    // layer priority
    // ----------------------------------------

    assign inBorder = (xD > coordT'(`BORDERX0)) && (xD < coordT'(`BORDERX1)) &&
                      (yD > coordT'(`BORDERY0)) && (yD < coordT'(`BORDERY1));
    assign inFloor  = (xD > coordT'(`FLOORX0)) && (xD < coordT'(`FLOORX1)) &&
                      (yD > coordT'(`FLOORY0)) && (yD < coordT'(`FLOORY1));

    always_comb
    begin
        // orange background
        red   = 8'hf3;
        green = 8'h69;
        blue  = 8'h0e;
        if (blankD)
        begin
            red   = channelOff;
            green = channelOff;
            blue  = channelOff;
        end
        else if (inFloor)
        begin
            // blue floor, sprite on top
            red   = isShooter ? spriteR : channelOff;
            green = isShooter ? spriteG : channelOff;
            blue  = isShooter ? spriteB : channelFull;
        end
        else if (inBorder)
        begin
            red   = channelOff;
            green = channelOff;
            blue  = channelOff;
        end
    end

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            vgaR  <= channelOff;
            vgaG  <= channelOff;
            vgaB  <= channelOff;
            vgaHs <= 1'b1;
            vgaVs <= 1'b1;
        end
        else
        begin
            vgaR  <= red;
            vgaG  <= green;
            vgaB  <= blue;
            vgaHs <= hsD;
            vgaVs <= vsD;
        end
    end

endmodule

// File: verilog/shooterDisplay.sv
// Clk must already be the 25 MHz pixel clock; keys are plain levels sampled once per frame
`timescale 1ns/1ps

module shooterDisplay
    import videoPkg::*, gamePkg::*;
(
    input  logic    Clk,
    input  logic    rstN,
    input  logic    keyUp,
    input  logic    keyRight,
    input  logic    keyDown,
    input  logic    keyLeft,
    output channelT vgaR,
    output channelT vgaG,
    output channelT vgaB,
    output logic    vgaHs,
    output logic    vgaVs,
    output coordT   shooterX,
    output coordT   shooterY,
    output facingT  shooterFace
);

    // ----------------------------------------
    // interconnect
    // ----------------------------------------

    coordT   drawX;
    coordT   drawY;
    logic    hs;
    logic    vs;
    logic    blank;
    logic    frameStart;
    logic    isShooter;
    channelT spriteR;
    channelT spriteG;
    channelT spriteB;

    // raster counters and sync windows
    vgaTiming timing (
        .Clk, .rstN, .drawX, .drawY, .hs, .vs, .blank, .frameStart
    );

    // per-frame movement
    shooterMotion motion (
        .Clk, .rstN, .frameStart, .keyUp, .keyRight, .keyDown, .keyLeft,
        .shooterX, .shooterY, .shooterFace
    );

    // sprite pixel, one clock late
    spriteTable sprite (
        .Clk, .rstN, .drawX, .drawY, .shooterX, .shooterY, .shooterFace,
        .isShooter, .spriteR, .spriteG, .spriteB
    );

    // layers and output registers
    colorMapper mapper (
        .Clk, .rstN, .drawX, .drawY, .hs, .vs, .blank,
        .isShooter, .spriteR, .spriteG, .spriteB,
        .vgaR, .vgaG, .vgaB, .vgaHs, .vgaVs
    );

endmodule

// File: bench/shooterDisplay_assert.sv
// checks are disabled while rstN is low; the colour check needs two clocks of history
`timescale 1ns/1ps

`include "game_defs.svh"

module shooterDisplayAssert
    import videoPkg::*;
(
    input logic    Clk,
    input logic    rstN,
    input logic    vgaHs,
    input logic    blank,
    input channelT vgaR,
    input channelT vgaG,
    input channelT vgaB,
    input coordT   shooterX,
    input coordT   shooterY
);

    // ----------------------------------------
    // hsync width counter
    // ----------------------------------------

    int hsLow;

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            hsLow <= 0;
        else
            hsLow <= vgaHs ? 0 : hsLow + 1;
    end

    // pulse ends after exactly HSYNC low clocks
    hsWidth: assert property (@(posedge Clk) disable iff (!rstN)
        $rose(vgaHs) |-> (hsLow == `HSYNC))
        else $error("vgaHs pulse was %0d clocks", hsLow);

    hsNotLong: assert property (@(posedge Clk) disable iff (!rstN)
        !vgaHs |-> (hsLow < `HSYNC))
        else $error("vgaHs low longer than the sync width");

    // blank from timing lands on the pins two clocks later
    blankDark: assert property (@(posedge Clk) disable iff (!rstN)
        $past(blank, 2) |-> (vgaR == '0 && vgaG == '0 && vgaB == '0))
        else $error("colour not zero during blank");

    // box fully on the floor
    onFloor: assert property (@(posedge Clk) disable iff (!rstN)
        (shooterX >= coordT'(`FLOORX0 + 1)) && (shooterX <= coordT'(`FLOORX1 - `SPRITESIZE)) &&
        (shooterY >= coordT'(`FLOORY0 + 1)) && (shooterY <= coordT'(`FLOORY1 - `SPRITESIZE)))
        else $error("shooter left the floor at %0d,%0d", shooterX, shooterY);

endmodule

bind shooterDisplay shooterDisplayAssert checks (
    .Clk, .rstN, .vgaHs, .blank, .vgaR, .vgaG, .vgaB, .shooterX, .shooterY
);

// File: bench/shooterDisplayTb.sv
// runs 12 frames with fixed-seed keys; the model restates the pixel, sync and motion rules
`timescale 1ns/1ps

`include "game_defs.svh"

module shooterDisplayTb
    import videoPkg::*, gamePkg::*;
();

    localparam int clkPeriod = 8;
    localparam int frameClocks = `HTOTAL * `VTOTAL;
    localparam int runFrames = 12;
    localparam longint watchdogNs = longint'(14) * frameClocks * clkPeriod;
    localparam int minX = `FLOORX0 + 1;
    localparam int maxX = `FLOORX1 - `SPRITESIZE;
    localparam int minY = `FLOORY0 + 1;
    localparam int maxY = `FLOORY1 - `SPRITESIZE;

    logic    Clk;
    logic    rstN;
    logic    keyUp;
    logic    keyRight;
    logic    keyDown;
    logic    keyLeft;
    channelT vgaR;
    channelT vgaG;
    channelT vgaB;
    logic    vgaHs;
    logic    vgaVs;
    coordT   shooterX;
    coordT   shooterY;
    facingT  shooterFace;

    int seed = 32'h21d70882;

    // model state, mirrors the raster and the shooter
    int      mH;
    int      mV;
    int      mX;
    int      mY;
    facingT  mFace;
    logic    mWrapped;
    logic    modelReady = 1'b0;
    int      moves = 0;
    // two-stage expected output pipe
    channelT p1R;
    channelT p1G;
    channelT p1B;
    logic    p1Hs;
    logic    p1Vs;
    channelT p2R;
    channelT p2G;
    channelT p2B;
    logic    p2Hs;
    logic    p2Vs;

    shooterDisplay uut (
        .Clk, .rstN, .keyUp, .keyRight, .keyDown, .keyLeft,
        .vgaR, .vgaG, .vgaB, .vgaHs, .vgaVs, .shooterX, .shooterY, .shooterFace
    );

    initial
    begin
        Clk = 1'b0;
        forever #(clkPeriod / 2) Clk = ~Clk;
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    // colour of one raster position with the current shooter state
    task automatic expectedPixel(input int x, input int y, output channelT r,
                                 output channelT g, output channelT b);
        int   u;
        int   v;
        logic body;
        logic barrel;
        u = x - mX;
        v = y - mY;
        body = (u >= 8) && (u <= 23) && (v >= 8) && (v <= 23);
        case (mFace)
            faceUp:    barrel = (u >= 14) && (u <= 17) && (v >= 0) && (v <= 7);
            faceRight: barrel = (v >= 14) && (v <= 17) && (u >= 24) && (u <= 31);
            faceDown:  barrel = (u >= 14) && (u <= 17) && (v >= 24) && (v <= 31);
            default:   barrel = (v >= 14) && (v <= 17) && (u >= 0) && (u <= 7);
        endcase
        r = 8'h00;
        g = 8'h00;
        b = 8'h00;
        // blanking stays dark
        if (x < `HVISIBLE && y < `VVISIBLE)
        begin
            if (body || barrel)
            begin
                // white body, red barrel
                r = 8'hff;
                g = body ? 8'hff : 8'h00;
                b = body ? 8'hff : 8'h00;
            end
            else if (x > `FLOORX0 && x < `FLOORX1 && y > `FLOORY0 && y < `FLOORY1)
                b = 8'hff;
            else if (!(x > `BORDERX0 && x < `BORDERX1 && y > `BORDERY0 && y < `BORDERY1))
            begin
                // orange outside the border
                r = 8'hf3;
                g = 8'h69;
                b = 8'h0e;
            end
        end
    endtask

    // one step per frame, up beats right beats down beats left
    task automatic applyKeys();
        if (keyUp)
        begin
            mFace = faceUp;
            mY = (mY - `STEP < minY) ? minY : mY - `STEP;
        end
        else if (keyRight)
        begin
            mFace = faceRight;
            mX = (mX + `STEP > maxX) ? maxX : mX + `STEP;
        end
        else if (keyDown)
        begin
            mFace = faceDown;
            mY = (mY + `STEP > maxY) ? maxY : mY + `STEP;
        end
        else if (keyLeft)
        begin
            mFace = faceLeft;
            mX = (mX - `STEP < minX) ? minX : mX - `STEP;
        end
    endtask

    always @(posedge Clk)
    begin
        if (!rstN)
        begin
            mH = 0;
            mV = 0;
            mX = `STARTX;
            mY = `STARTY;
            mFace = faceUp;
            mWrapped = 1'b0;
            {p1R, p1G, p1B, p2R, p2G, p2B} = '0;
            {p1Hs, p1Vs, p2Hs, p2Vs} = 4'b1111;
            modelReady = 1'b1;
        end
        else
        begin
            int lastX;
            int lastY;
            p2R = p1R;
            p2G = p1G;
            p2B = p1B;
            p2Hs = p1Hs;
            p2Vs = p1Vs;
            expectedPixel(mH, mV, p1R, p1G, p1B);
            p1Hs = !(mH >= 656 && mH <= 751);
            p1Vs = !(mV == 490 || mV == 491);
            // frame start, keys sampled here, no move on the first frame
            if (mH == 0 && mV == 0 && mWrapped)
            begin
                lastX = mX;
                lastY = mY;
                applyKeys();
                if (mX != lastX || mY != lastY)
                    moves++;
            end
            if (mH == `HTOTAL - 1)
            begin
                mH = 0;
                if (mV == `VTOTAL - 1)
                begin
                    mV = 0;
                    mWrapped = 1'b1;
                end
                else
                    mV = mV + 1;
            end
            else
                mH = mH + 1;
        end
    end

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------

    task automatic checkChannel(input string name, input channelT expected, input channelT actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic checkCoord(input string name, input coordT expected, input coordT actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED t=%0t %s expected %0d got %0d", $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic checkFacing(input string name, input facingT expected, input facingT actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED t=%0t %s expected %s got %s", $time, name,
                     expected.name(), actual.name());
            $display(">>> FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic checkSync(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED t=%0t %s expected %b got %b", $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // outputs settled, compare on the falling edge
    always @(negedge Clk)
    begin
        if (modelReady)
        begin
            checkChannel("vgaR", p2R, vgaR);
            checkChannel("vgaG", p2G, vgaG);
            checkChannel("vgaB", p2B, vgaB);
            checkSync("vgaHs", p2Hs, vgaHs);
            checkSync("vgaVs", p2Vs, vgaVs);
            checkCoord("shooterX", coordT'(mX), shooterX);
            checkCoord("shooterY", coordT'(mY), shooterY);
            checkFacing("shooterFace", mFace, shooterFace);
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    // mostly one key, sometimes none or a mix, bit 12 holds the old keys
    task automatic pickKeys();
        int         r;
        logic [3:0] keys;
        r = $random(seed);
        if (!r[12])
        begin
            case (r[2:0])
                3'd0:    keys = 4'b0000;
                3'd1:    keys = r[7:4];
                default: keys = 4'b0001 << r[9:8];
            endcase
            keyUp    <= keys[0];
            keyRight <= keys[1];
            keyDown  <= keys[2];
            keyLeft  <= keys[3];
        end
    endtask

    initial
    begin
        int frame;
        rstN     <= 1'b0;
        keyUp    <= 1'b0;
        keyRight <= 1'b0;
        keyDown  <= 1'b0;
        keyLeft  <= 1'b0;
        repeat (8) @(posedge Clk);
        rstN <= 1'b1;
        for (frame = 0; frame < runFrames; frame++)
        begin
            pickKeys();
            repeat (frameClocks) @(posedge Clk);
        end
        if (moves == 0)
        begin
            $display("run ended without the shooter moving once");
            $display(">>> FAIL");
            $fatal(1, "stimulus never moved the shooter");
        end
        else
        begin
            $display(">>> PASS");
            $finish;
        end
    end

    // watchdog, two frames of slack
    initial
    begin
        #(watchdogNs);
        $display("run timed out before the last frame finished");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: sources.f
+incdir+verilog
verilog/videoPkg.sv
verilog/gamePkg.sv
verilog/vgaTiming.sv
verilog/shooterMotion.sv
verilog/spriteTable.sv
verilog/colorMapper.sv
verilog/shooterDisplay.sv
bench/shooterDisplay_assert.sv
bench/shooterDisplayTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the shooter display testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module shooterDisplayTb \
    --Mdir obj_dir -o simv

# a failing run may exit non-zero, the pass line decides the result
output="$(./obj_dir/simv 2>&1)" || true
echo "$output"

if grep -Fxq ">>> PASS" <<< "$output"; then
    exit 0
else
    exit 1
fi
